// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_isa_pkg.sv
  - common/core_cfg_pkg.sv
  - source/pc_counter.sv
  - source/stage_reg.sv
  - source/inst_mem.sv
  - decode/id.sv
  - execute/ex.sv
  - source/reg_file.sv
  - source/rv_core_top.sv
  - target: simulation
    files:
      - verif/rv_core_chk.sv
      - verif/tb_rv_core.sv

// ==== common/core_cfg_pkg.sv ====
package core_cfg_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] inst_addr;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       inst;
        logic [XLEN-1:0]       inst_addr;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic                  reg_wen;
    } id_ex_t;

    localparam if_id_t IF_ID_BUBBLE = '{inst: rv_isa_pkg::INST_NOP, inst_addr: '0};

    localparam id_ex_t ID_EX_BUBBLE = '{
        inst:      rv_isa_pkg::INST_NOP,
        inst_addr: '0,
        op1:       '0,
        op2:       '0,
        rd_addr:   '0,
        reg_wen:   1'b0
    };

endpackage

// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] INST_TYPE_I   = 7'b0010011;
    localparam logic [6:0] INST_TYPE_R_M = 7'b0110011;
    localparam logic [6:0] INST_TYPE_B   = 7'b1100011;
    localparam logic [6:0] INST_JAL      = 7'b1101111;
    localparam logic [6:0] INST_JALR     = 7'b1100111;
    localparam logic [6:0] INST_LUI      = 7'b0110111;

    // I-type func3
    localparam logic [2:0] INST_ADDI  = 3'b000;
    localparam logic [2:0] INST_SLTI  = 3'b010;
    localparam logic [2:0] INST_SLTIU = 3'b011;
    localparam logic [2:0] INST_XORI  = 3'b100;
    localparam logic [2:0] INST_ORI   = 3'b110;
    localparam logic [2:0] INST_ANDI  = 3'b111;
    localparam logic [2:0] INST_SLLI  = 3'b001;
    localparam logic [2:0] INST_SRI   = 3'b101; // srli and srai, split by bit 30

    // R-type func3
    localparam logic [2:0] INST_ADD_SUB = 3'b000;
    localparam logic [2:0] INST_SLL     = 3'b001;
    localparam logic [2:0] INST_SLT     = 3'b010;
    localparam logic [2:0] INST_SLTU    = 3'b011;
    localparam logic [2:0] INST_XOR     = 3'b100;
    localparam logic [2:0] INST_SR      = 3'b101;
    localparam logic [2:0] INST_OR      = 3'b110;
    localparam logic [2:0] INST_AND     = 3'b111;

    // branch func3
    localparam logic [2:0] INST_BEQ  = 3'b000;
    localparam logic [2:0] INST_BNE  = 3'b001;
    localparam logic [2:0] INST_BLT  = 3'b100;
    localparam logic [2:0] INST_BGE  = 3'b101;
    localparam logic [2:0] INST_BLTU = 3'b110;
    localparam logic [2:0] INST_BGEU = 3'b111;

    localparam logic [31:0] INST_NOP = 32'h0000_0013; // addi x0, x0, 0

    function automatic logic [31:0] imm_i(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [31:0] imm_b(input logic [31:0] inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(input logic [31:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

endpackage

// ==== compile.f ====
common/rv_isa_pkg.sv
common/core_cfg_pkg.sv
source/pc_counter.sv
source/stage_reg.sv
source/inst_mem.sv
decode/id.sv
execute/ex.sv
source/reg_file.sv
source/rv_core_top.sv
verif/rv_core_chk.sv
verif/tb_rv_core.sv

// ==== decode/id.sv ====
`timescale 1ns/1ps

module id (
    input  core_cfg_pkg::if_id_t                if_id_i,
    input  logic                                fetch_valid_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       rs1_rdata_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       rs2_rdata_i,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1_raddr_o,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2_raddr_o,
    output core_cfg_pkg::id_ex_t                id_ex_o
);

    localparam int XLEN       = core_cfg_pkg::XLEN;
    localparam int REG_ADDR_W = core_cfg_pkg::REG_ADDR_W;

    logic [XLEN-1:0]       inst;
    logic [6:0]            opcode;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_nz;

    assign inst   = fetch_valid_i ? if_id_i.inst : rv_isa_pkg::INST_NOP;
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign rd_nz  = (rd != '0); // x0 writes never leave decode

    assign rs1_raddr_o = inst[19:15];
    assign rs2_raddr_o = inst[24:20];

    always_comb begin
        id_ex_o.inst      = inst;
        id_ex_o.inst_addr = if_id_i.inst_addr;
        id_ex_o.op1       = rs1_rdata_i;
        id_ex_o.op2       = rs2_rdata_i;
        id_ex_o.rd_addr   = rd;
        id_ex_o.reg_wen   = 1'b0;
        case (opcode)
            rv_isa_pkg::INST_TYPE_I: begin
                id_ex_o.op2     = rv_isa_pkg::imm_i(inst);
                id_ex_o.reg_wen = rd_nz;
            end
            rv_isa_pkg::INST_TYPE_R_M: begin
                id_ex_o.reg_wen = rd_nz;
            end
            rv_isa_pkg::INST_JAL: begin
                id_ex_o.op1     = rv_isa_pkg::imm_j(inst); // offset, pc added in ex
                id_ex_o.op2     = '0;
                id_ex_o.reg_wen = rd_nz;
            end
            rv_isa_pkg::INST_JALR: begin
                id_ex_o.op2     = rv_isa_pkg::imm_i(inst);
                id_ex_o.reg_wen = rd_nz;
            end
            rv_isa_pkg::INST_LUI: begin
                id_ex_o.op1     = rv_isa_pkg::imm_u(inst);
                id_ex_o.op2     = '0;
                id_ex_o.reg_wen = rd_nz;
            end
            default: begin
                id_ex_o.reg_wen = 1'b0; // branches and anything unsupported
            end
        endcase
    end

endmodule

// ==== execute/ex.sv ====
`timescale 1ns/1ps

module ex (
    input  core_cfg_pkg::id_ex_t                id_ex_i,
    output logic [core_cfg_pkg::XLEN-1:0]       rd_wdata_o,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_waddr_o,
    output logic                                reg_wen_o,
    output logic [core_cfg_pkg::XLEN-1:0]       jump_addr_o,
    output logic                                jump_en_o
);

    localparam int XLEN = core_cfg_pkg::XLEN;

    logic [6:0]      opcode;
    logic [2:0]      func3;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_mask;
    logic [XLEN-1:0] sra_res;
    logic [XLEN-1:0] alu_res;
    logic            br_take;

    assign opcode = id_ex_i.inst[6:0];
    assign func3  = id_ex_i.inst[14:12];
    assign op1    = id_ex_i.op1;
    assign op2    = id_ex_i.op2;

    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    // shift amount from op2 serves both the immediate and register forms
    assign srl_res  = op1 >> op2[4:0];
    assign sra_mask = {XLEN{1'b1}} >> op2[4:0];
    assign sra_res  = (srl_res & sra_mask) | ({XLEN{op1[XLEN-1]}} & ~sra_mask);

    // I and R share func3 codes
    always_comb begin
        case (func3)
            rv_isa_pkg::INST_ADD_SUB: begin
                if (opcode == rv_isa_pkg::INST_TYPE_R_M && id_ex_i.inst[30]) begin
                    alu_res = op1 - op2;
                end else begin
                    alu_res = op1 + op2;
                end
            end
            rv_isa_pkg::INST_SLL:  alu_res = op1 << op2[4:0];
            rv_isa_pkg::INST_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            rv_isa_pkg::INST_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            rv_isa_pkg::INST_XOR:  alu_res = op1 ^ op2;
            rv_isa_pkg::INST_SR:   alu_res = id_ex_i.inst[30] ? sra_res : srl_res;
            rv_isa_pkg::INST_OR:   alu_res = op1 | op2;
            rv_isa_pkg::INST_AND:  alu_res = op1 & op2;
        endcase
    end

    always_comb begin
        case (func3)
            rv_isa_pkg::INST_BEQ:  br_take = eq;
            rv_isa_pkg::INST_BNE:  br_take = ~eq;
            rv_isa_pkg::INST_BLT:  br_take = lt_s;
            rv_isa_pkg::INST_BGE:  br_take = ~lt_s;
            rv_isa_pkg::INST_BLTU: br_take = lt_u;
            rv_isa_pkg::INST_BGEU: br_take = ~lt_u;
            default:               br_take = 1'b0;
        endcase
    end

    always_comb begin
        rd_wdata_o  = alu_res;
        rd_waddr_o  = id_ex_i.rd_addr;
        reg_wen_o   = 1'b0;
        jump_addr_o = '0;
        jump_en_o   = 1'b0;
        case (opcode)
            rv_isa_pkg::INST_TYPE_I, rv_isa_pkg::INST_TYPE_R_M: begin
                reg_wen_o = id_ex_i.reg_wen;
            end
            rv_isa_pkg::INST_TYPE_B: begin
                jump_addr_o = id_ex_i.inst_addr + rv_isa_pkg::imm_b(id_ex_i.inst);
                jump_en_o   = br_take;
            end
            rv_isa_pkg::INST_JAL: begin
                rd_wdata_o  = id_ex_i.inst_addr + XLEN'(4); // link
                reg_wen_o   = id_ex_i.reg_wen;
                jump_addr_o = id_ex_i.inst_addr + op1;
                jump_en_o   = 1'b1;
            end
            rv_isa_pkg::INST_JALR: begin
                rd_wdata_o  = id_ex_i.inst_addr + XLEN'(4);
                reg_wen_o   = id_ex_i.reg_wen;
                jump_addr_o = (op1 + op2) & ~XLEN'(1); // lsb cleared per spec
                jump_en_o   = 1'b1;
            end
            rv_isa_pkg::INST_LUI: begin
                rd_wdata_o = op1;
                reg_wen_o  = id_ex_i.reg_wen;
            end
            default: begin
                reg_wen_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/inst_mem.sv ====
`timescale 1ns/1ps

module inst_mem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk_i,
    input  logic                          we_i,
    input  logic [core_cfg_pkg::XLEN-1:0] waddr_i,
    input  logic [core_cfg_pkg::XLEN-1:0] wdata_i,
    input  logic [core_cfg_pkg::XLEN-1:0] raddr_i,
    output logic [core_cfg_pkg::XLEN-1:0] rdata_o
);

    localparam int XLEN = core_cfg_pkg::XLEN;
    localparam int AW   = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] mem [IMEM_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i[AW+1:2]] <= wdata_i; // byte address to word index
        end
    end

    assign rdata_o = mem[raddr_i[AW+1:2]];

endmodule

// ==== source/pc_counter.sv ====
`timescale 1ns/1ps

module pc_counter #(
    parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          run_i,
    input  logic                          jump_en_i,
    input  logic [core_cfg_pkg::XLEN-1:0] jump_addr_i,
    output logic [core_cfg_pkg::XLEN-1:0] pc_o,
    output logic                          fetch_valid_o
);

    localparam int XLEN = core_cfg_pkg::XLEN;

    logic [XLEN-1:0] pc_q;
    logic            run_q;
    logic            valid_q; // word now sitting in if_id was fetched while running

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= RESET_PC;
            run_q   <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            run_q   <= run_i;
            valid_q <= run_q;
            if (jump_en_i) begin
                pc_q <= jump_addr_i;
            end else if (run_q) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    assign pc_o          = pc_q;
    assign fetch_valid_o = valid_q;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                we_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       wdata_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_cfg_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_cfg_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_cfg_pkg::XLEN-1:0]       rdata2_o
);

    localparam int XLEN  = core_cfg_pkg::XLEN;
    localparam int NREGS = 2 ** core_cfg_pkg::REG_ADDR_W;

    logic [XLEN-1:0] regs [NREGS];
    logic            wr_ok;

    assign wr_ok = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // same-cycle write goes straight to the read port
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (wr_ok && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (wr_ok && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter int                            IMEM_DEPTH = 256,
    parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC   = '0
) (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                run_i,
    input  logic                                imem_we_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       imem_addr_i,
    input  logic [core_cfg_pkg::XLEN-1:0]       imem_wdata_i,
    output logic                                wb_en_o,
    output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [core_cfg_pkg::XLEN-1:0]       wb_data_o
);

    localparam int XLEN       = core_cfg_pkg::XLEN;
    localparam int REG_ADDR_W = core_cfg_pkg::REG_ADDR_W;

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       fetch_inst;
    logic                  fetch_valid;
    logic                  jump_en;
    logic [XLEN-1:0]       jump_addr;
    logic [REG_ADDR_W-1:0] rs1_raddr;
    logic [REG_ADDR_W-1:0] rs2_raddr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;

    core_cfg_pkg::if_id_t if_id_d;
    core_cfg_pkg::if_id_t if_id_q;
    core_cfg_pkg::id_ex_t id_ex_d;
    core_cfg_pkg::id_ex_t id_ex_q;

    assign if_id_d.inst      = fetch_inst;
    assign if_id_d.inst_addr = pc;

    pc_counter #(
        .RESET_PC (RESET_PC)
    ) u_pc_counter (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .run_i         (run_i),
        .jump_en_i     (jump_en),
        .jump_addr_i   (jump_addr),
        .pc_o          (pc),
        .fetch_valid_o (fetch_valid)
    );

    inst_mem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_inst_mem (
        .clk_i   (clk_i),
        .we_i    (imem_we_i),
        .waddr_i (imem_addr_i),
        .wdata_i (imem_wdata_i),
        .raddr_i (pc),
        .rdata_o (fetch_inst)
    );

    stage_reg #(
        .payload_t (core_cfg_pkg::if_id_t),
        .FLUSH_VAL (core_cfg_pkg::IF_ID_BUBBLE)
    ) u_if_id (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (jump_en),
        .d_i      (if_id_d),
        .q_o      (if_id_q)
    );

    id u_id (
        .if_id_i       (if_id_q),
        .fetch_valid_i (fetch_valid),
        .rs1_rdata_i   (rs1_rdata),
        .rs2_rdata_i   (rs2_rdata),
        .rs1_raddr_o   (rs1_raddr),
        .rs2_raddr_o   (rs2_raddr),
        .id_ex_o       (id_ex_d)
    );

    stage_reg #(
        .payload_t (core_cfg_pkg::id_ex_t),
        .FLUSH_VAL (core_cfg_pkg::ID_EX_BUBBLE)
    ) u_id_ex (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (jump_en),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    ex u_ex (
        .id_ex_i     (id_ex_q),
        .rd_wdata_o  (wb_data_o),
        .rd_waddr_o  (wb_addr_o),
        .reg_wen_o   (wb_en_o),
        .jump_addr_o (jump_addr),
        .jump_en_o   (jump_en)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .we_i     (wb_en_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (rs1_raddr),
        .raddr2_i (rs2_raddr),
        .rdata1_o (rs1_rdata),
        .rdata2_o (rs2_rdata)
    );

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type      payload_t = logic,
    parameter payload_t FLUSH_VAL = '0
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    payload_t q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q <= FLUSH_VAL;
        end else if (flush_i) begin
            q <= FLUSH_VAL; // drop wrong-path work
        end else begin
            q <= d_i;
        end
    end

    assign q_o = q;

endmodule

// ==== verif/rv_core_chk.sv ====
`timescale 1ns/1ps

module rv_core_chk (
    input logic                                clk_i,
    input logic                                arst_n_i,
    input logic                                wb_en_i,
    input logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input logic                                jump_en_i
);

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !wb_en_i)
        else begin
            fail_count++;
            $error("register write while reset is asserted");
        end

    // flush leaves two empty execute slots
    jump_bubbles: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        jump_en_i |=> !wb_en_i [*2])
        else begin
            fail_count++;
            $error("register write within two cycles of a jump");
        end

    no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_en_i |-> (wb_addr_i != '0))
        else begin
            fail_count++;
            $error("write to x0 reached write-back");
        end

endmodule

bind rv_core_top rv_core_chk u_chk (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wb_en_i   (wb_en_o),
    .wb_addr_i (wb_addr_o),
    .jump_en_i (jump_en)
);

// ==== verif/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          XLEN = core_cfg_pkg::XLEN;
    localparam logic [31:0] HALT = 32'h0000_006F; // jal x0, 0

    bit              clk_i;
    logic            arst_n_i;
    logic            run_i;
    logic            imem_we_i;
    logic [XLEN-1:0] imem_addr_i;
    logic [XLEN-1:0] imem_wdata_i;
    logic            wb_en_o;
    logic [4:0]      wb_addr_o;
    logic [XLEN-1:0] wb_data_o;

    logic [31:0] prog [$];
    logic [36:0] exp_q [$]; // {rd, data} in write order
    logic [36:0] exp_w;
    int          n_exp;
    int          n_writes;
    int          n_checks;
    int          n_errors;
    int          cycles;
    int          limit;

    rv_core_top #(
        .IMEM_DEPTH (256),
        .RESET_PC   ('0)
    ) dut_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .run_i        (run_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial begin
        forever #20 clk_i = ~clk_i;
    end

    task automatic compare_val(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::INST_TYPE_I};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::INST_TYPE_R_M};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::INST_TYPE_B};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::INST_JAL};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // instruction-set model, queues every register write in program order
    function automatic void run_ref();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        logic        take;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        pc = '0;
        for (int step = 0; step < 4 * prog.size(); step++) begin
            inst = prog[pc[31:2]];
            if (inst == HALT) begin
                break;
            end
            a    = x[inst[19:15]];
            b    = x[inst[24:20]];
            imm  = {{20{inst[31]}}, inst[31:20]};
            res  = pc + 4; // link value
            nxt  = pc + 4;
            wr   = 1'b1;
            take = 1'b0;
            case (inst[6:0])
                rv_isa_pkg::INST_TYPE_I:
                    res = alu_ref(inst[14:12], inst[14:12] == 3'd5 && inst[30], a, imm);
                rv_isa_pkg::INST_TYPE_R_M: res = alu_ref(inst[14:12], inst[30], a, b);
                rv_isa_pkg::INST_LUI:      res = {inst[31:12], 12'b0};
                rv_isa_pkg::INST_JAL:
                    nxt = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                rv_isa_pkg::INST_JALR:     nxt = (a + imm) & ~32'd1;
                rv_isa_pkg::INST_TYPE_B: begin
                    wr = 1'b0;
                    case (inst[14:12])
                        rv_isa_pkg::INST_BEQ:  take = (a == b);
                        rv_isa_pkg::INST_BNE:  take = (a != b);
                        rv_isa_pkg::INST_BLT:  take = ($signed(a) < $signed(b));
                        rv_isa_pkg::INST_BGE:  take = ($signed(a) >= $signed(b));
                        rv_isa_pkg::INST_BLTU: take = (a < b);
                        default:               take = (a >= b);
                    endcase
                    if (take) begin
                        nxt = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                x[inst[11:7]] = res;
                exp_q.push_back({inst[11:7], res});
            end
            pc = nxt;
        end
    endfunction

    task automatic build_prog();
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [2:0]  br_f3 [6];
        int          p;
        br_f3 = '{rv_isa_pkg::INST_BEQ, rv_isa_pkg::INST_BNE, rv_isa_pkg::INST_BLT,
                  rv_isa_pkg::INST_BGE, rv_isa_pkg::INST_BLTU, rv_isa_pkg::INST_BGEU};
        for (int r = 1; r < 32; r++) begin // random start value in every register
            prog.push_back({20'($urandom()), 5'(r), rv_isa_pkg::INST_LUI});
            prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'(r), 5'(r), 12'($urandom())));
        end
        for (int k = 0; k < 48; k++) begin
            f3  = 3'(k >> 1); // every func3 in both forms, three rounds
            alt = ((k >> 4) == 1); // middle round takes sub and the arithmetic shifts
            rd  = 5'($urandom_range(31, 1));
            imm = 12'($urandom());
            if (f3 == 3'd1) imm[11:5] = 7'd0;
            if (f3 == 3'd5) imm[11:5] = {1'b0, alt, 5'd0}; // srli or srai
            if (k % 2 == 1) begin
                prog.push_back(enc_r(((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00,
                                     f3, rd, 5'($urandom()), 5'($urandom())));
            end else begin
                prog.push_back(enc_i(f3, rd, 5'($urandom()), imm));
            end
        end
        // mixed-sign operands and a dependent chain
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd1, 5'd0, 12'hffb));
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd2, 5'd0, 12'd3));
        prog.push_back(enc_r(7'h00, rv_isa_pkg::INST_SLT, 5'd3, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h00, rv_isa_pkg::INST_SLTU, 5'd4, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h20, rv_isa_pkg::INST_SR, 5'd6, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h00, rv_isa_pkg::INST_SR, 5'd7, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h20, rv_isa_pkg::INST_ADD_SUB, 5'd8, 5'd2, 5'd1));
        prog.push_back(enc_r(7'h00, rv_isa_pkg::INST_ADD_SUB, 5'd8, 5'd8, 5'd8));
        prog.push_back(enc_i(rv_isa_pkg::INST_XORI, 5'd8, 5'd8, 12'hfff));
        // each branch tries (x1,x2), (x2,x1) and (x1,x1), skipping one addi when taken
        foreach (br_f3[i]) begin
            for (int j = 0; j < 3; j++) begin
                prog.push_back(enc_b(br_f3[i], (j == 1) ? 5'd2 : 5'd1,
                                     (j == 0) ? 5'd2 : 5'd1, 13'd8));
                prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd5, 5'd5, 12'd1));
            end
        end
        p = prog.size();
        prog.push_back({20'($urandom()), 5'd9, rv_isa_pkg::INST_LUI});
        prog.push_back(enc_j(5'd10, 21'd12)); // to p+4
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd5, 5'd5, 12'd100));
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd5, 5'd5, 12'd100));
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd11, 5'd0, 12'((p + 7) * 4 - 3)));
        prog.push_back({12'd4, 5'd11, 3'b000, 5'd12, rv_isa_pkg::INST_JALR}); // odd sum, to p+7
        prog.push_back(enc_i(rv_isa_pkg::INST_ADDI, 5'd5, 5'd5, 12'd100));
        prog.push_back(enc_r(7'h00, rv_isa_pkg::INST_ADD_SUB, 5'd13, 5'd12, 5'd10));
        prog.push_back(HALT);
    endtask

    // write-back sampled mid-cycle, away from the edges
    always @(negedge clk_i) begin
        if (!arst_n_i || !run_i) begin
            compare_val("wb_en_o while idle", 32'(wb_en_o), 32'd0);
        end else if (wb_en_o) begin
            n_writes++;
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Error at %0t: write to x%0d that the model does not make",
                         $time, wb_addr_o);
            end else begin
                exp_w = exp_q.pop_front();
                compare_val("wb_addr_o", 32'(wb_addr_o), 32'(exp_w[36:32]));
                compare_val("wb_data_o", wb_data_o, exp_w[31:0]);
            end
        end
    end

    always @(posedge clk_i) begin
        if (run_i) begin
            cycles <= cycles + 1;
        end
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, %0d of %0d expected writes seen",
                     cycles, n_writes, n_exp);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(52044));
        arst_n_i     = 1'b0;
        run_i        = 1'b0;
        imem_we_i    = 1'b0;
        imem_addr_i  = '0;
        imem_wdata_i = '0;
        n_writes     = 0;
        n_checks     = 0;
        n_errors     = 0;
        cycles       = 0;
        build_prog();
        run_ref();
        n_exp = exp_q.size();
        limit = 4 * prog.size() + 100;
        repeat (5) @(posedge clk_i);
        arst_n_i <= 1'b1;
        foreach (prog[i]) begin
            @(posedge clk_i);
            imem_we_i    <= 1'b1;
            imem_addr_i  <= 32'(i * 4);
            imem_wdata_i <= prog[i];
        end
        @(posedge clk_i);
        imem_we_i <= 1'b0;
        run_i     <= 1'b1;
        wait (n_writes >= n_exp);
        repeat (20) @(posedge clk_i); // halt loop must stay silent
        compare_val("write count", 32'(n_writes), 32'(n_exp));
        if (dut_i.u_chk.fail_count != 0) begin
            n_errors += dut_i.u_chk.fail_count;
            $display("%0d assertion failures in the bound checker", dut_i.u_chk.fail_count);
        end
        $display("%0d checks, %0d writes of %0d expected, %0d errors",
                 n_checks, n_writes, n_exp, n_errors);
        if (n_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
